// File: hdl/apb_bus_pkg.sv
`default_nettype none

package apb_bus_pkg;

        // --------------------
        // Bus widths
        // --------------------
        typedef logic [31:0] apb_addr_t;        // APB address
        typedef logic [31:0] apb_data_t;        // PRDATA / PWDATA
        typedef logic [3:0]  apb_slot_t;        // Slot field of the address

        // --------------------
        // Slot decode
        // --------------------
        localparam int        SLOT_LSB = 12;    // Slot field is paddr[15:12]
        localparam apb_slot_t SLOT_ADC = 4'd0;  // ADC register block

        // Register offsets inside a slot
        localparam logic [SLOT_LSB-1:0] REG_CTRL_OFS   = 12'h000;
        localparam logic [SLOT_LSB-1:0] REG_STATUS_OFS = 12'h004;
        localparam logic [SLOT_LSB-1:0] REG_DATA_OFS   = 12'h008;

endpackage

`default_nettype wire

// File: hdl/adc_pkg.sv
`default_nettype none

package adc_pkg;

        // Converter result width
        localparam int ADC_WIDTH = 12;

        typedef logic [ADC_WIDTH-1:0] adc_sample_t;     // One conversion result

        // --------------------
        // Sequencer states
        // --------------------
        typedef enum logic [2:0] {
                SEQ_IDLE,       // Waiting for a trigger
                SEQ_START,      // conv_start high
                SEQ_WAIT_EOC,   // Converter busy
                SEQ_READ,       // conv_oe high, converter drives data
                SEQ_CAPTURE     // Sample registered, sample_done high
        } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/apb_slave_mux.sv
`timescale 1ns/1ps
`default_nettype none

module apb_slave_mux (
        input  wire  apb_bus_pkg::apb_addr_t paddr,
        input  wire                          psel,
        input  wire  apb_bus_pkg::apb_data_t prdata_adc,
        input  wire                          pready_adc,
        input  wire                          pslverr_adc,
        output logic                         psel_adc,
        output apb_bus_pkg::apb_data_t       prdata,
        output logic                         pready,
        output logic                         pslverr
);

        import apb_bus_pkg::*;

        apb_slot_t slot;        // paddr[15:12]
        logic      adc_hit;

        assign slot    = paddr[SLOT_LSB +: $bits(apb_slot_t)];
        assign adc_hit = (slot == SLOT_ADC);

        // Select only the addressed slave
        assign psel_adc = psel & adc_hit;

        // --------------------
        // Return path
        // --------------------
        always_comb begin
                case (slot)
                        SLOT_ADC: begin
                                prdata  = prdata_adc;
                                pready  = pready_adc;
                                pslverr = pslverr_adc;
                        end
                        default: begin
                                // Slots 1..3 and above are empty
                                prdata  = '0;           // No data from a hole
                                pready  = 1'b1;         // Complete at once
                                pslverr = psel;         // Flag the bad access
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: hdl/adc_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module adc_apb_regs (
        input  wire                          clk,
        input  wire                          RSTn,
        input  wire                          psel,
        input  wire                          penable,
        input  wire                          pwrite,
        input  wire  apb_bus_pkg::apb_addr_t paddr,
        input  wire  apb_bus_pkg::apb_data_t pwdata,
        input  wire                          seq_busy,
        input  wire                          sample_done,
        input  wire  adc_pkg::adc_sample_t   sample_data,
        output apb_bus_pkg::apb_data_t       prdata,
        output logic                         pready,
        output logic                         pslverr,
        output logic                         sample_trigger,
        output logic                         stream_valid,
        output adc_pkg::adc_sample_t         stream_data
);

        import apb_bus_pkg::*;
        import adc_pkg::*;

        logic [SLOT_LSB-1:0] ofs;       // Offset inside the slot
        logic                hit_ctrl;
        logic                hit_status;
        logic                hit_data;
        logic                access;    // Access phase, always completes
        logic                ctrl_wr;
        logic                data_rd;

        logic                stream_en; // CTRL bit1
        logic                valid;     // STATUS bit0
        logic                overrun;   // STATUS bit2
        adc_sample_t         data_q;    // DATA register

        // --------------------
        // Decode
        // --------------------
        assign ofs        = paddr[SLOT_LSB-1:0];
        assign hit_ctrl   = (ofs == REG_CTRL_OFS);
        assign hit_status = (ofs == REG_STATUS_OFS);
        assign hit_data   = (ofs == REG_DATA_OFS);

        assign access  = psel & penable;
        assign ctrl_wr = access & pwrite & hit_ctrl;
        assign data_rd = access & ~pwrite & hit_data;

        assign pready  = 1'b1;                                  // Zero wait states
        assign pslverr = psel & ~(hit_ctrl | hit_status | hit_data);

        // Read mux, unknown offsets return zero
        always_comb begin
                if (hit_ctrl)
                        prdata = apb_data_t'({stream_en, 1'b0});        // Trigger reads 0
                else if (hit_status)
                        prdata = apb_data_t'({overrun, seq_busy, valid});
                else if (hit_data)
                        prdata = apb_data_t'(data_q);           // Zero above bit 11
                else
                        prdata = '0;
        end

        // --------------------
        // Control and status
        // --------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        sample_trigger <= 1'b0;
                        stream_en      <= 1'b0;
                        valid          <= 1'b0;
                        overrun        <= 1'b0;
                        data_q         <= '0;
                        stream_valid   <= 1'b0;
                end else begin
                        sample_trigger <= ctrl_wr & pwdata[0];  // One-cycle pulse
                        stream_valid   <= sample_done & stream_en;
                        if (ctrl_wr)
                                stream_en <= pwdata[1];
                        if (ctrl_wr && pwdata[2])
                                overrun <= 1'b0;                // Write-one-to-clear
                        if (data_rd)
                                valid <= 1'b0;
                        // New sample wins over a read or clear in the same cycle
                        if (sample_done) begin
                                data_q <= sample_data;
                                valid  <= 1'b1;
                                if (valid && !data_rd)
                                        overrun <= 1'b1;        // Old sample lost
                        end
                end
        end

        // Stream payload, qualified by stream_valid
        always_ff @(posedge clk) begin
                if (sample_done)
                        stream_data <= sample_data;
        end

endmodule

`default_nettype wire

// File: hdl/adc_sample_seq.sv
`timescale 1ns/1ps
`default_nettype none

module adc_sample_seq (
        input  wire                        clk,
        input  wire                        RSTn,
        input  wire                        sample_trigger,
        input  wire                        conv_eoc,
        input  wire  adc_pkg::adc_sample_t conv_data,
        output logic                       conv_start,
        output logic                       conv_oe,
        output logic                       seq_busy,
        output logic                       sample_done,
        output adc_pkg::adc_sample_t       sample_data
);

        import adc_pkg::*;

        seq_state_t state;
        seq_state_t state_nxt;

        // --------------------
        // Next state
        // --------------------
        always_comb begin
                state_nxt = state;
                case (state)
                        SEQ_IDLE:
                                if (sample_trigger)
                                        state_nxt = SEQ_START;  // Only IDLE sees triggers
                        SEQ_START:
                                state_nxt = SEQ_WAIT_EOC;       // Start is one cycle
                        SEQ_WAIT_EOC:
                                if (conv_eoc)
                                        state_nxt = SEQ_READ;
                        SEQ_READ:
                                state_nxt = SEQ_CAPTURE;
                        SEQ_CAPTURE:
                                state_nxt = SEQ_IDLE;
                        default:
                                state_nxt = SEQ_IDLE;           // Unused codes recover
                endcase
        end

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn)
                        state <= SEQ_IDLE;
                else
                        state <= state_nxt;
        end

        // Converter drives conv_data while conv_oe is high
        always_ff @(posedge clk) begin
                if (state == SEQ_READ)
                        sample_data <= conv_data;
        end

        // --------------------
        // Outputs from state
        // --------------------
        assign conv_start  = (state == SEQ_START);
        assign conv_oe     = (state == SEQ_READ);      // Cycle after EOC
        assign sample_done = (state == SEQ_CAPTURE);   // Cycle after OE
        assign seq_busy    = (state != SEQ_IDLE);

endmodule

`default_nettype wire

// File: hdl/adc_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_subsys_top (
        input  wire                          clk,
        input  wire                          RSTn,
        input  wire  apb_bus_pkg::apb_addr_t paddr,
        input  wire                          psel,
        input  wire                          penable,
        input  wire                          pwrite,
        input  wire  apb_bus_pkg::apb_data_t pwdata,
        input  wire                          conv_eoc,
        input  wire  adc_pkg::adc_sample_t   conv_data,
        output wire  apb_bus_pkg::apb_data_t prdata,
        output wire                          pready,
        output wire                          pslverr,
        output wire                          conv_start,
        output wire                          conv_oe,
        output wire                          stream_valid,
        output wire  adc_pkg::adc_sample_t   stream_data
);

        import apb_bus_pkg::*;
        import adc_pkg::*;

        // ADC slot of the APB mux
        wire            psel_adc;
        apb_data_t      prdata_adc;
        wire            pready_adc;
        wire            pslverr_adc;

        // Registers to sequencer
        wire            sample_trigger;
        wire            seq_busy;
        wire            sample_done;
        adc_sample_t    sample_data;

        apb_slave_mux i_mux (
                .paddr          (paddr),
                .psel           (psel),
                .prdata_adc     (prdata_adc),
                .pready_adc     (pready_adc),
                .pslverr_adc    (pslverr_adc),
                .psel_adc       (psel_adc),
                .prdata         (prdata),
                .pready         (pready),
                .pslverr        (pslverr)
        );

        adc_apb_regs i_regs (
                .clk            (clk),
                .RSTn           (RSTn),
                .psel           (psel_adc),
                .penable        (penable),
                .pwrite         (pwrite),
                .paddr          (paddr),
                .pwdata         (pwdata),
                .seq_busy       (seq_busy),
                .sample_done    (sample_done),
                .sample_data    (sample_data),
                .prdata         (prdata_adc),
                .pready         (pready_adc),
                .pslverr        (pslverr_adc),
                .sample_trigger (sample_trigger),
                .stream_valid   (stream_valid),  // adc2tmu path
                .stream_data    (stream_data)
        );

        adc_sample_seq i_seq (
                .clk            (clk),
                .RSTn           (RSTn),
                .sample_trigger (sample_trigger),
                .conv_eoc       (conv_eoc),
                .conv_data      (conv_data),
                .conv_start     (conv_start),
                .conv_oe        (conv_oe),
                .seq_busy       (seq_busy),
                .sample_done    (sample_done),
                .sample_data    (sample_data)
        );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
        output logic clk,
        output logic RSTn
);

        localparam int PERIOD     = 10;         // ns
        localparam int RST_CYCLES = 5;

        initial begin
                clk = 1'b0;
                forever #(PERIOD / 2) clk = ~clk;
        end

        // Release on a rising edge, like any other stimulus
        initial begin
                RSTn = 1'b0;
                repeat (RST_CYCLES) @(posedge clk);
                RSTn <= 1'b1;
        end

endmodule

`default_nettype wire

// File: tb/adc_subsys_props.sv
`timescale 1ns/1ps
`default_nettype none

module adc_subsys_props (
        input wire clk,
        input wire RSTn,
        input wire conv_start,
        input wire conv_eoc,
        input wire conv_oe,
        input wire sample_done
);

        int fail_count = 0;     // Read by the testbench top

        // Start strobe lasts one cycle
        start_one_cycle: assert property (@(posedge clk) disable iff (!RSTn)
                conv_start |=> !conv_start)
        else begin
                fail_count++;
                $error("conv_start held longer than one cycle");
        end

        // Output enable right after end of conversion
        oe_after_eoc: assert property (@(posedge clk) disable iff (!RSTn)
                (conv_eoc |=> conv_oe) and (conv_oe |-> $past(conv_eoc)))
        else begin
                fail_count++;
                $error("conv_oe not one cycle after conv_eoc");
        end

        done_after_oe: assert property (@(posedge clk) disable iff (!RSTn)
                (conv_oe |=> sample_done) and (sample_done |-> $past(conv_oe)))
        else begin
                fail_count++;
                $error("sample_done not one cycle after conv_oe");
        end

endmodule

bind adc_sample_seq adc_subsys_props i_props (.*);

`default_nettype wire

// File: tb/adc_subsys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module adc_subsys_checker (
        input  wire                          clk,
        input  wire                          RSTn,
        input  wire  apb_bus_pkg::apb_addr_t paddr,
        input  wire                          psel,
        input  wire                          penable,
        input  wire                          pwrite,
        input  wire  apb_bus_pkg::apb_data_t pwdata,
        input  wire  apb_bus_pkg::apb_data_t prdata,
        input  wire                          pready,
        input  wire                          pslverr,
        input  wire                          conv_start,
        input  wire                          conv_eoc,
        input  wire                          conv_oe,
        input  wire                          stream_valid,
        input  wire  adc_pkg::adc_sample_t   stream_data,
        input  wire                          conv_value_vld,
        input  wire  adc_pkg::adc_sample_t   conv_value,
        output int                           error_count,
        output int                           read_count,
        output int                           sample_count
);

        import apb_bus_pkg::*;
        import adc_pkg::*;

        // --------------------
        // Register model, values of the current cycle
        // --------------------
        logic        trig;              // Trigger pulse
        int          phase;             // 0 idle, 1 start, 2 wait EOC, 3 OE, 4 done
        logic        stream_en;
        logic        valid;
        logic        overrun;
        adc_sample_t data;
        adc_sample_t sample;            // Last value from the converter model
        logic        strm_vld;
        adc_sample_t strm_data;

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        error_count++;
                        $display("error at %0t ns: %s is %0h, expected %0h",
                                 $time, name, got, exp);
                end
        endtask

        initial begin
                error_count  = 0;
                read_count   = 0;
                sample_count = 0;
        end

        // Sample at the falling edge, all inputs settled
        always @(negedge clk) begin : compare
                apb_slot_t           slot;
                logic [SLOT_LSB-1:0] ofs;
                logic                access;
                logic                ofs_ok;
                logic                ctrl_wr;
                logic                data_rd;
                logic                done;
                apb_data_t           exp_rd;

                slot   = paddr[SLOT_LSB +: 4];
                ofs    = paddr[SLOT_LSB-1:0];
                access = psel & penable;
                ofs_ok = (slot == SLOT_ADC) && (ofs == REG_CTRL_OFS ||
                         ofs == REG_STATUS_OFS || ofs == REG_DATA_OFS);
                if (!RSTn) begin
                        trig      = 1'b0;
                        phase     = 0;
                        stream_en = 1'b0;
                        valid     = 1'b0;
                        overrun   = 1'b0;
                        data      = '0;
                        sample    = '0;
                        strm_vld  = 1'b0;
                        strm_data = '0;
                end else begin
                        // One per accepted trigger
                        check_value("conv_start", conv_start, phase == 1);
                        check_value("conv_oe", conv_oe, phase == 3);
                        check_value("stream_valid", stream_valid, strm_vld);
                        if (strm_vld) begin
                                check_value("stream_data", stream_data, strm_data);
                                sample_count++;
                        end

                        // --------------------
                        // APB access cycle
                        // --------------------
                        if (access) begin
                                check_value("pready", pready, 1);
                                check_value("pslverr", pslverr, !ofs_ok);
                                if (!ofs_ok)
                                        exp_rd = '0;
                                else if (ofs == REG_CTRL_OFS)
                                        exp_rd = apb_data_t'({stream_en, 1'b0});
                                else if (ofs == REG_STATUS_OFS)
                                        exp_rd = apb_data_t'({overrun, phase != 0, valid});
                                else
                                        exp_rd = apb_data_t'(data);
                                if (!pwrite || !ofs_ok)
                                        check_value("prdata", prdata, exp_rd);
                                if (!pwrite)
                                        read_count++;
                        end

                        // Advance the model by one cycle
                        ctrl_wr = access && pwrite && ofs_ok && ofs == REG_CTRL_OFS;
                        data_rd = access && !pwrite && ofs_ok && ofs == REG_DATA_OFS;
                        done    = (phase == 4);
                        if (phase == 3) begin
                                if (!conv_value_vld) begin
                                        error_count++;
                                        $display("Converter model gave no sample %s %0t ns",
                                                 "during conv_oe at", $time);
                                end
                                sample = conv_value;
                        end
                        strm_vld = done && stream_en;   // Old enable
                        if (done)
                                strm_data = sample;
                        case (phase)
                                0:       phase = trig ? 1 : 0;  // Busy triggers dropped
                                2:       phase = conv_eoc ? 3 : 2;
                                4:       phase = 0;
                                default: phase = phase + 1;
                        endcase
                        trig = ctrl_wr && pwdata[0];
                        if (ctrl_wr)
                                stream_en = pwdata[1];
                        if (ctrl_wr && pwdata[2])
                                overrun = 1'b0;
                        if (data_rd)
                                valid = 1'b0;
                        if (done) begin
                                if (valid)
                                        overrun = 1'b1; // Unread sample overwritten
                                data  = sample;
                                valid = 1'b1;
                        end
                end
        end

endmodule

`default_nettype wire

// File: tb/adc_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adc_subsys_tb;

        import apb_bus_pkg::*;
        import adc_pkg::*;

        localparam logic [31:0] SEED      = 32'd51743;
        localparam int          N_OPS     = 300;
        localparam int          DELAY_MAX = 20;
        localparam int          CONV_MAX  = DELAY_MAX + 4;     // Start to done
        localparam int          CLK_NS    = 10;
        localparam int          WDOG_CYC  = (N_OPS + 20) * (CONV_MAX + 10);

        localparam apb_addr_t ADDR_CTRL   = {20'h0, REG_CTRL_OFS};
        localparam apb_addr_t ADDR_STATUS = {20'h0, REG_STATUS_OFS};
        localparam apb_addr_t ADDR_DATA   = {20'h0, REG_DATA_OFS};

        wire         clk;
        wire         RSTn;
        apb_addr_t   paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        apb_data_t   pwdata;
        logic        conv_eoc;
        adc_sample_t conv_data;
        wire         [31:0] prdata;
        wire         pready;
        wire         pslverr;
        wire         conv_start;
        wire         conv_oe;
        wire         stream_valid;
        wire         [11:0] stream_data;

        logic        conv_value_vld;    // Converter model to checker
        adc_sample_t conv_value;
        int          chk_errors;
        int          read_count;
        int          sample_count;

        logic [31:0] stim_seed = SEED;
        logic [31:0] conv_seed = ~SEED; // Own stream for the converter

        tb_clk_gen i_clk_gen (
                .clk  (clk),
                .RSTn (RSTn)
        );

        adc_subsys_top i_dut (
                .clk          (clk),
                .RSTn         (RSTn),
                .paddr        (paddr),
                .psel         (psel),
                .penable      (penable),
                .pwrite       (pwrite),
                .pwdata       (pwdata),
                .conv_eoc     (conv_eoc),
                .conv_data    (conv_data),
                .prdata       (prdata),
                .pready       (pready),
                .pslverr      (pslverr),
                .conv_start   (conv_start),
                .conv_oe      (conv_oe),
                .stream_valid (stream_valid),
                .stream_data  (stream_data)
        );

        adc_subsys_checker i_chk (
                .clk            (clk),
                .RSTn           (RSTn),
                .paddr          (paddr),
                .psel           (psel),
                .penable        (penable),
                .pwrite         (pwrite),
                .pwdata         (pwdata),
                .prdata         (prdata),
                .pready         (pready),
                .pslverr        (pslverr),
                .conv_start     (conv_start),
                .conv_eoc       (conv_eoc),
                .conv_oe        (conv_oe),
                .stream_valid   (stream_valid),
                .stream_data    (stream_data),
                .conv_value_vld (conv_value_vld),
                .conv_value     (conv_value),
                .error_count    (chk_errors),
                .read_count     (read_count),
                .sample_count   (sample_count)
        );

        function automatic logic [31:0] lcg(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic draw(output logic [15:0] r);
                stim_seed = lcg(stim_seed);
                r = stim_seed[31:16];           // Upper bits, longer period
        endtask

        // --------------------
        // APB master
        // --------------------
        task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata);
                @(posedge clk);
                psel    <= 1'b1;                // Setup phase
                penable <= 1'b0;
                pwrite  <= wr;
                paddr   <= addr;
                pwdata  <= wdata;
                @(posedge clk);
                penable <= 1'b1;                // Access phase
                @(posedge clk);
                while (pready !== 1'b1)
                        @(posedge clk);
                rdata = prdata;
                psel    <= 1'b0;
                penable <= 1'b0;
        endtask

        task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
                apb_data_t unused;
                apb_xfer(1'b1, addr, wdata, unused);
        endtask

        task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
                apb_xfer(1'b0, addr, '0, rdata);
        endtask

        // Poll STATUS until one bit reaches a level
        task automatic poll_status(input int bit_idx, input logic value);
                apb_data_t st;
                apb_read(ADDR_STATUS, st);
                while (st[bit_idx] !== value)
                        apb_read(ADDR_STATUS, st);
        endtask

        // --------------------
        // Converter model
        // --------------------
        always begin : converter
                int unsigned delay;
                @(posedge clk);
                if (conv_start) begin
                        conv_seed = lcg(conv_seed);
                        delay = 1 + conv_seed[31:16] % DELAY_MAX;       // 1..20 cycles
                        repeat (delay - 1) @(posedge clk);
                        conv_eoc <= 1'b1;
                        @(posedge clk);
                        conv_seed = lcg(conv_seed);
                        conv_eoc       <= 1'b0;
                        conv_data      <= conv_seed[31:20];     // Held through the OE cycle
                        conv_value     <= conv_seed[31:20];
                        conv_value_vld <= 1'b1;
                        @(posedge clk);
                        conv_data      <= ~conv_seed[31:20];    // Junk outside OE
                        conv_value_vld <= 1'b0;
                end
        end

        initial begin : stimulus
                apb_data_t   rd;
                logic [15:0] r;
                logic [15:0] a;
                int          total;

                paddr          = '0;
                psel           = 1'b0;
                penable        = 1'b0;
                pwrite         = 1'b0;
                pwdata         = '0;
                conv_eoc       = 1'b0;
                conv_data      = '0;
                conv_value     = '0;
                conv_value_vld = 1'b0;
                wait (RSTn === 1'b1);

                // Reset values, then one streamed conversion
                apb_read(ADDR_STATUS, rd);
                apb_read(ADDR_CTRL, rd);
                apb_write(ADDR_CTRL, 32'h3);
                poll_status(0, 1'b1);
                apb_read(ADDR_DATA, rd);
                apb_read(ADDR_STATUS, rd);

                // Overrun, trigger while busy, overrun clear
                apb_write(ADDR_CTRL, 32'h1);
                poll_status(1, 1'b0);
                apb_write(ADDR_CTRL, 32'h1);
                apb_write(ADDR_CTRL, 32'h1);    // Lands while busy
                poll_status(1, 1'b0);
                apb_read(ADDR_STATUS, rd);
                apb_write(ADDR_CTRL, 32'h4);
                apb_read(ADDR_STATUS, rd);

                // --------------------
                // Random operations
                // --------------------
                for (int i = 0; i < N_OPS; i++) begin
                        draw(r);
                        draw(a);
                        case (r[2:0])
                                3'd0: apb_write(ADDR_CTRL, apb_data_t'(a[2:0]));
                                3'd1: apb_write(ADDR_CTRL, apb_data_t'({a[1], 1'b1}));
                                3'd2: apb_read(ADDR_STATUS, rd);
                                3'd3: apb_read(ADDR_DATA, rd);
                                3'd4: apb_read(ADDR_CTRL, rd);
                                3'd5: apb_xfer(r[3], {16'h0, apb_slot_t'(1 + a % 3), a[11:0]},
                                               {a, r}, rd);     // Unmapped slot
                                3'd6: apb_xfer(r[3], {20'h0, 12'h00C + a[11:0] % 12'hFF4},
                                               {a, r}, rd);     // Hole in slot 0
                                default: begin
                                        apb_write(ADDR_CTRL, apb_data_t'({r[4], 1'b1}));
                                        poll_status(0, 1'b1);
                                        apb_read(ADDR_DATA, rd);
                                        apb_read(ADDR_STATUS, rd);
                                end
                        endcase
                        repeat (int'(r[15:14])) @(posedge clk); // Idle gap
                end

                // Let the last conversion and stream pulse drain
                poll_status(1, 1'b0);
                repeat (5) @(posedge clk);

                total = chk_errors + i_dut.i_seq.i_props.fail_count;
                $display("Checked %0d reads and %0d stream samples: %0d checker errors, %0d %s",
                         read_count, sample_count, chk_errors,
                         i_dut.i_seq.i_props.fail_count, "assertion errors");
                if (total == 0)
                        $display("TESTBENCH PASSED");
                else
                        $display("TESTBENCH FAILED");
                $finish;
        end

        initial begin : watchdog
                #(WDOG_CYC * CLK_NS);
                $display("Timeout: the run did not finish within %0d clock cycles", WDOG_CYC);
                $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: all.f
hdl/apb_bus_pkg.sv
hdl/adc_pkg.sv
hdl/apb_slave_mux.sv
hdl/adc_apb_regs.sv
hdl/adc_sample_seq.sv
hdl/adc_subsys_top.sv
tb/tb_clk_gen.sv
tb/adc_subsys_props.sv
tb/adc_subsys_checker.sv
tb/adc_subsys_tb.sv

// File: Bender.yml
package:
  name: adc_subsys

sources:
  - hdl/apb_bus_pkg.sv
  - hdl/adc_pkg.sv
  - hdl/apb_slave_mux.sv
  - hdl/adc_apb_regs.sv
  - hdl/adc_sample_seq.sv
  - hdl/adc_subsys_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/adc_subsys_props.sv
      - tb/adc_subsys_checker.sv
      - tb/adc_subsys_tb.sv
